// File: rtl/board_config.svh
// Build constants for the board management I2C, PLL init, debounce and reset tail

`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// Clock cycles per quarter SCL period (small value for simulation)
`define I2C_PRESCALE 4

// 7-bit address of the PLL on the management bus
`define PLL_I2C_ADDR 7'h68

// Number of register writes in the PLL init table
`define PLL_INIT_LEN 6

// Cycles between switch samples
`define DEBOUNCE_RATE 16

// Equal consecutive samples needed before a switch value is taken
`define DEBOUNCE_DEPTH 4

// Cycles the core reset stays asserted once the last write has finished
`define RST_TAIL 4

// Switch and LED width
`define SW_W 4

`endif

// File: rtl/board_pkg.sv
// Shared types for the board management logic: I2C bytes, table index and FSM states

package board_pkg;

// One byte on the I2C wire
typedef logic [7:0] byte_t;

// Entry number in the PLL init table
typedef logic [2:0] init_idx_t;

// I2C master states
// START and STOP generate the bus conditions, BIT shifts a data bit,
// ACK releases SDA for the target's acknowledge
typedef enum logic [2:0] {
    IDLE,
    START,
    BIT,
    ACK,
    STOP
} i2c_state_t;

// PLL init sequencer states
// RUN issues the next write, WAIT follows it to the end,
// TAIL holds core reset a few more cycles, DONE and ERR are final
typedef enum logic [2:0] {
    RUN,
    WAIT,
    TAIL,
    DONE,
    ERR
} seq_state_t;

endpackage

// File: rtl/pll_init_rom.sv
// PLL init table: register address and data for each configuration write

`resetall
`timescale 1ns / 1ps
`default_nettype none

module pll_init_rom
    import board_pkg::*;
(
    input  wire init_idx_t reg_idx_i,
    output byte_t          reg_addr_o,
    output byte_t          reg_data_o
);

// Writes go out in table order, so the final entry
// is the one that kicks off the PLL calibration
always_comb begin
    case (reg_idx_i)
        3'd0: begin
            reg_addr_o = 8'h01;
            reg_data_o = 8'h00;
        end
        3'd1: begin
            reg_addr_o = 8'h02;
            reg_data_o = 8'h3c;
        end
        3'd2: begin
            reg_addr_o = 8'h08;
            reg_data_o = 8'h05;
        end
        3'd3: begin
            reg_addr_o = 8'h0a;
            reg_data_o = 8'h14;
        end
        3'd4: begin
            reg_addr_o = 8'h10;
            reg_data_o = 8'h81;
        end
        3'd5: begin
            reg_addr_o = 8'h03;
            reg_data_o = 8'h01;
        end
        default: begin
            reg_addr_o = 8'h00;
            reg_data_o = 8'h00;
        end
    endcase
end

endmodule

`resetall

// File: rtl/pll_init_seq.sv
// PLL init sequencer: one I2C write per table entry, then core reset release

`resetall
`timescale 1ns / 1ps
`default_nettype none

`include "board_config.svh"

module pll_init_seq
    import board_pkg::*;
(
    input  wire logic clk_125mhz_i,
    input  wire logic rst_i,

    // I2C master handshake
    input  wire logic busy_i,
    input  wire logic nack_i,
    output init_idx_t reg_idx_o,
    output logic      start_o,

    // Status
    output logic      core_rst_o,
    output logic      init_done_o,
    output logic      init_err_o
);

localparam int TAIL_W = $clog2(`RST_TAIL + 1);
localparam init_idx_t LAST_IDX = init_idx_t'(`PLL_INIT_LEN - 1);

seq_state_t state_q;
logic busy_d;
logic busy_fall;
logic [TAIL_W-1:0] tail_q;

assign busy_fall = busy_d && !busy_i;

assign core_rst_o  = (state_q != DONE);
assign init_done_o = (state_q == DONE);
assign init_err_o  = (state_q == ERR);

always_ff @(posedge clk_125mhz_i) begin
    start_o <= 1'b0;
    if (rst_i) begin
        state_q   <= RUN;
        reg_idx_o <= '0;
        busy_d    <= 1'b0;
        tail_q    <= '0;
    end else begin
        busy_d <= busy_i;
        case (state_q)
            RUN: begin
                if (!busy_i) begin
                    start_o <= 1'b1;
                    state_q <= WAIT;
                end
            end
            WAIT: begin
                if (busy_fall) begin
                    if (nack_i) begin
                        state_q <= ERR;
                    end else if (reg_idx_o == LAST_IDX) begin
                        // Fall is seen a cycle late and DONE lands a cycle after zero
                        tail_q  <= TAIL_W'(`RST_TAIL - 2);
                        state_q <= TAIL;
                    end else begin
                        reg_idx_o <= reg_idx_o + 3'd1;
                        state_q   <= RUN;
                    end
                end
            end
            TAIL: begin
                if (tail_q == '0) begin
                    state_q <= DONE;
                end else begin
                    tail_q <= tail_q - 1'b1;
                end
            end
            // DONE and ERR hold until reset
            default: state_q <= state_q;
        endcase
    end
end

endmodule

`resetall

// File: rtl/i2c_master.sv
// I2C write engine: start, device address, register address, data byte, stop

`resetall
`timescale 1ns / 1ps
`default_nettype none

`include "board_config.svh"

module i2c_master
    import board_pkg::*;
(
    input  wire logic  clk_125mhz_i,
    input  wire logic  rst_i,

    // Command side, address and data held stable while busy
    input  wire logic  start_i,
    input  wire byte_t reg_addr_i,
    input  wire byte_t reg_data_i,

    // Open-drain bus, 1 releases the line
    input  wire logic  scl_i,
    input  wire logic  sda_i,
    output logic       scl_o,
    output logic       sda_o,

    // Status
    output logic       busy_o,
    output logic       nack_o
);

localparam int PRESC_W = $clog2(`I2C_PRESCALE + 1);

// Device address with the write bit
localparam byte_t DEV_ADDR_WR = {`PLL_I2C_ADDR, 1'b0};

i2c_state_t state_q;
logic [1:0] phase_q;
logic [PRESC_W-1:0] presc_q;
logic [2:0] bit_q;
logic [1:0] byte_q;
byte_t shift_q;
logic nack_q;
logic tick;
logic scl_d;
logic sda_d;

// End of one quarter bit
assign tick = (presc_q == PRESC_W'(`I2C_PRESCALE - 1));

assign busy_o = (state_q != IDLE);

// Bus levels per state and quarter; SDA only moves while SCL is low
always_comb begin
    scl_d = 1'b1;
    sda_d = 1'b1;
    case (state_q)
        START: begin
            sda_d = (phase_q == 2'd0);
            scl_d = (phase_q != 2'd3);
        end
        BIT: begin
            sda_d = shift_q[7];
            scl_d = (phase_q == 2'd1) || (phase_q == 2'd2);
        end
        ACK: begin
            scl_d = (phase_q == 2'd1) || (phase_q == 2'd2);
        end
        STOP: begin
            sda_d = phase_q[1];
            scl_d = (phase_q != 2'd0);
        end
        default: begin
            scl_d = 1'b1;
        end
    endcase
end

always_ff @(posedge clk_125mhz_i) begin
    nack_o <= 1'b0;
    if (rst_i) begin
        state_q <= IDLE;
        phase_q <= '0;
        presc_q <= '0;
        bit_q   <= '0;
        byte_q  <= '0;
        nack_q  <= 1'b0;
        scl_o   <= 1'b1;
        sda_o   <= 1'b1;
    end else begin
        scl_o <= scl_d;
        sda_o <= sda_d;
        if (state_q == IDLE) begin
            presc_q <= '0;
            phase_q <= '0;
            if (start_i) begin
                state_q <= START;
                bit_q   <= 3'd7;
                byte_q  <= '0;
                nack_q  <= 1'b0;
            end
        end else begin
            presc_q <= tick ? '0 : presc_q + 1'b1;
            if (tick) begin
                phase_q <= phase_q + 2'd1;
                // Mid-high ACK sample, an SCL still held low counts as a miss
                if (state_q == ACK && phase_q == 2'd1 && (sda_i || !scl_i)) begin
                    nack_q <= 1'b1;
                end
                if (phase_q == 2'd3) begin
                    case (state_q)
                        START: state_q <= BIT;
                        BIT: begin
                            bit_q <= bit_q - 3'd1;
                            if (bit_q == 3'd0) begin
                                state_q <= ACK;
                            end
                        end
                        ACK: begin
                            bit_q   <= 3'd7;
                            byte_q  <= byte_q + 2'd1;
                            state_q <= (byte_q == 2'd2) ? STOP : BIT;
                        end
                        default: begin
                            state_q <= IDLE;
                            nack_o  <= nack_q;
                        end
                    endcase
                end
            end
        end
    end
end

// Byte shifter, MSB first; next byte loaded at the end of each ACK
always_ff @(posedge clk_125mhz_i) begin
    if (state_q == IDLE && start_i) begin
        shift_q <= DEV_ADDR_WR;
    end else if (tick && phase_q == 2'd3) begin
        if (state_q == BIT) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end else if (state_q == ACK) begin
            shift_q <= (byte_q == 2'd0) ? reg_addr_i : reg_data_i;
        end
    end
end

endmodule

`resetall

// File: rtl/input_cond.sv
// Input conditioning: switch debounce and UART handshake synchronizer

`resetall
`timescale 1ns / 1ps
`default_nettype none

`include "board_config.svh"

module input_cond (
    input  wire logic             clk_125mhz_i,
    input  wire logic             rst_i,
    input  wire logic [`SW_W-1:0] sw_i,
    input  wire logic             uart_txd_i,
    input  wire logic             uart_rts_i,
    output logic      [`SW_W-1:0] sw_o,
    output logic                  uart_txd_o,
    output logic                  uart_rts_o
);

localparam int RATE_W = $clog2(`DEBOUNCE_RATE + 1);

logic [RATE_W-1:0] rate_q;
logic sample;
logic [`SW_W-1:0][`DEBOUNCE_DEPTH-1:0] hist_q;
// UART lines packed as {txd, rts}
logic [1:0] uart_s1;
logic [1:0] uart_s2;

assign sample = (rate_q == RATE_W'(`DEBOUNCE_RATE - 1));

always_ff @(posedge clk_125mhz_i) begin
    if (rst_i) begin
        rate_q <= '0;
        hist_q <= '0;
        sw_o   <= '0;
    end else begin
        rate_q <= sample ? '0 : rate_q + 1'b1;
        for (int i = 0; i < `SW_W; i++) begin
            if (sample) begin
                hist_q[i] <= {hist_q[i][`DEBOUNCE_DEPTH-2:0], sw_i[i]};
            end
            // Mixed history keeps the old value
            if (&hist_q[i]) begin
                sw_o[i] <= 1'b1;
            end else if (~|hist_q[i]) begin
                sw_o[i] <= 1'b0;
            end
        end
    end
end

always_ff @(posedge clk_125mhz_i) begin
    uart_s1 <= {uart_txd_i, uart_rts_i};
    uart_s2 <= uart_s1;
end

assign uart_txd_o = uart_s2[1];
assign uart_rts_o = uart_s2[0];

endmodule

`resetall

// File: rtl/board_top.sv
// Board management top: PLL init over I2C, core reset hold and input conditioning

`resetall
`timescale 1ns / 1ps
`default_nettype none

`include "board_config.svh"

module board_top
    import board_pkg::*;
(
    input  wire logic             clk_125mhz_i,
    input  wire logic             rst_i,

    // GPIO and UART handshake
    input  wire logic [`SW_W-1:0] sw_i,
    input  wire logic             uart_txd_i,
    input  wire logic             uart_rts_i,

    // Management I2C, open-drain enables
    input  wire logic             scl_i,
    input  wire logic             sda_i,
    output wire logic             scl_o,
    output wire logic             sda_o,

    // Conditioned inputs toward the core
    output wire logic [`SW_W-1:0] sw_o,
    output wire logic             uart_txd_o,
    output wire logic             uart_rts_o,

    // Core reset and init status
    output wire logic             core_rst_o,
    output wire logic             init_done_o,
    output wire logic             init_err_o
);

init_idx_t reg_idx;
byte_t reg_addr;
byte_t reg_data;
logic i2c_start;
logic i2c_busy;
logic i2c_nack;

pll_init_seq seq_inst (
    .clk_125mhz_i(clk_125mhz_i),
    .rst_i(rst_i),
    .busy_i(i2c_busy),
    .nack_i(i2c_nack),
    .reg_idx_o(reg_idx),
    .start_o(i2c_start),
    .core_rst_o(core_rst_o),
    .init_done_o(init_done_o),
    .init_err_o(init_err_o)
);

pll_init_rom rom_inst (
    .reg_idx_i(reg_idx),
    .reg_addr_o(reg_addr),
    .reg_data_o(reg_data)
);

i2c_master i2c_master_inst (
    .clk_125mhz_i(clk_125mhz_i),
    .rst_i(rst_i),
    .start_i(i2c_start),
    .reg_addr_i(reg_addr),
    .reg_data_i(reg_data),
    .scl_i(scl_i),
    .sda_i(sda_i),
    .scl_o(scl_o),
    .sda_o(sda_o),
    .busy_o(i2c_busy),
    .nack_o(i2c_nack)
);

input_cond input_cond_inst (
    .clk_125mhz_i(clk_125mhz_i),
    .rst_i(rst_i),
    .sw_i(sw_i),
    .uart_txd_i(uart_txd_i),
    .uart_rts_i(uart_rts_i),
    .sw_o(sw_o),
    .uart_txd_o(uart_txd_o),
    .uart_rts_o(uart_rts_o)
);

endmodule

`resetall

// File: sim/board_assert.sv
// Concurrent checks on core reset, I2C clock activity and init status of the board top

`timescale 1ns/1ps

module board_assert (
    input logic clk_i,
    input logic rst_i,
    input logic scl_oe_i,
    input logic core_rst_i,
    input logic init_done_i,
    input logic init_err_i
);

// Core stays in reset until init is done
core_rst_held: assert property (@(posedge clk_i) disable iff (rst_i)
    !init_done_i |-> core_rst_i)
    else $error("core_rst_o low while init_done_o is low");

// SCL only toggles while init is still running
scl_idle_after_init: assert property (@(posedge clk_i) disable iff (rst_i)
    !scl_oe_i |-> (!init_done_i && !init_err_i))
    else $error("scl_o driven low after init finished");

status_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(init_done_i && init_err_i))
    else $error("init_done_o and init_err_o high together");

endmodule

bind board_top board_assert assert0 (
    .clk_i(clk_125mhz_i),
    .rst_i(rst_i),
    .scl_oe_i(scl_o),
    .core_rst_i(core_rst_o),
    .init_done_i(init_done_o),
    .init_err_i(init_err_o)
);

// File: sim/board_tb.sv
// Testbench for the board top: PLL init over I2C, NACK abort, switch debounce and UART sync

`timescale 1ns/1ps

`include "board_config.svh"

module board_tb
    import board_pkg::*;
();

// Start, 27 bit slots (three bytes plus ACKs) and stop, four quarters each
localparam int XFER_CYC = (2 + 27) * 4 * `I2C_PRESCALE;
localparam int NACK_WATCH_CYC = 3 * XFER_CYC;
localparam int SW_ROWS = 5;
localparam int SW_HOLD_MAX = 120;
localparam int SETTLE_CYC = (`DEBOUNCE_DEPTH + 1) * `DEBOUNCE_RATE;
localparam int SW_ROW_CYC = SW_HOLD_MAX + `DEBOUNCE_RATE + SETTLE_CYC;
localparam int TIMEOUT_CYC = `PLL_INIT_LEN * 3 * XFER_CYC + SW_ROWS * SW_ROW_CYC + 1000;
localparam byte_t EXP_DEV = 8'hd0;

logic clk;
logic rst;
logic [`SW_W-1:0] sw;
logic uart_txd;
logic uart_rts;
logic scl_oe;
logic sda_oe;
logic scl_bus;
logic sda_bus;
logic [`SW_W-1:0] sw_out;
logic txd_out;
logic rts_out;
logic core_rst;
logic init_done;
logic init_err;

// Expected PLL writes, register then data
byte_t exp_reg [`PLL_INIT_LEN] = '{8'h01, 8'h02, 8'h08, 8'h0a, 8'h10, 8'h03};
byte_t exp_dat [`PLL_INIT_LEN] = '{8'h00, 8'h3c, 8'h05, 8'h14, 8'h81, 8'h01};

// Switch rows: value driven, cycles held, value expected on sw_o
logic [`SW_W-1:0] sw_val_tab [SW_ROWS] = '{4'h5, 4'ha, 4'hf, 4'h0, 4'h3};
int               sw_hold_tab [SW_ROWS] = '{88, 96, 100, 90, 120};
logic [`SW_W-1:0] sw_exp_tab [SW_ROWS] = '{4'h5, 4'ha, 4'hf, 4'h0, 4'h3};

logic [31:0] lfsr_q;
logic [2:0] txd_hist = '0;
logic [2:0] rts_hist = '0;
int cycle_cnt = 0;
string waiting_for = "reset";

// Target model state
logic nack_mode = 1'b0;
logic tgt_sda_low = 1'b0;
logic scl_prev;
logic sda_prev;
logic in_xfer;
logic [3:0] bit_cnt;
byte_t rx_shift;
int xfer_bytes;
int stop_cnt;
byte_t rx_q [$];
logic done_seen = 1'b0;

// Open-drain bus, no clock stretching by the target
assign scl_bus = scl_oe;
assign sda_bus = sda_oe & ~tgt_sda_low;

board_top dut0 (
    .clk_125mhz_i(clk),
    .rst_i(rst),
    .sw_i(sw),
    .uart_txd_i(uart_txd),
    .uart_rts_i(uart_rts),
    .scl_i(scl_bus),
    .sda_i(sda_bus),
    .scl_o(scl_oe),
    .sda_o(sda_oe),
    .sw_o(sw_out),
    .uart_txd_o(txd_out),
    .uart_rts_o(rts_out),
    .core_rst_o(core_rst),
    .init_done_o(init_done),
    .init_err_o(init_err)
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

task automatic end_with_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
endtask

task automatic fail_reason(input string msg);
    $display("%s", msg);
    end_with_failure();
endtask

task automatic check_byte(input string name, input byte_t exp, input byte_t got);
    if (got !== exp) begin
        $display("ERR %s exp=%h got=%h", name, exp, got);
        end_with_failure();
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
        $display("ERR %s exp=%h got=%h", name, exp, got);
        end_with_failure();
    end
endtask

task automatic check_state(input string name, input seq_state_t exp, input seq_state_t got);
    if (got !== exp) begin
        $display("ERR %s exp=%h got=%h", name, exp, got);
        end_with_failure();
    end
endtask

// x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
endfunction

function automatic int lfsr_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
        v = (v << 1) | int'(lfsr_bit());
    end
    return v;
endfunction

always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
        fail_reason($sformatf("Timeout after %0d cycles waiting for %s",
                              cycle_cnt, waiting_for));
    end
end

// I2C target: start/stop detection, bytes taken at SCL rise, ACK driven after each byte
always @(posedge clk) begin
    if (rst) begin
        scl_prev    <= 1'b1;
        sda_prev    <= 1'b1;
        in_xfer     <= 1'b0;
        bit_cnt     <= '0;
        tgt_sda_low <= 1'b0;
        xfer_bytes  <= 0;
        stop_cnt    <= 0;
        rx_q.delete();
    end else begin
        scl_prev <= scl_bus;
        sda_prev <= sda_bus;
        if (scl_prev && scl_bus && sda_prev && !sda_bus) begin
            in_xfer    <= 1'b1;
            bit_cnt    <= '0;
            xfer_bytes <= 0;
        end else if (scl_prev && scl_bus && !sda_prev && sda_bus) begin
            in_xfer  <= 1'b0;
            stop_cnt <= stop_cnt + 1;
            if (in_xfer && xfer_bytes != 3) begin
                fail_reason($sformatf("Stop after %0d bytes instead of 3", xfer_bytes));
            end
        end else if (in_xfer && !scl_prev && scl_bus) begin
            if (bit_cnt < 4'd8) begin
                rx_shift <= {rx_shift[6:0], sda_bus};
            end
            bit_cnt <= bit_cnt + 4'd1;
        end else if (in_xfer && scl_prev && !scl_bus) begin
            if (bit_cnt == 4'd8) begin
                rx_q.push_back(rx_shift);
                xfer_bytes  <= xfer_bytes + 1;
                tgt_sda_low <= !nack_mode;
            end else if (bit_cnt == 4'd9) begin
                tgt_sda_low <= 1'b0;
                bit_cnt     <= '0;
            end
        end
    end
end

// Core reset mirrors init_done, and done holds once seen
always @(negedge clk) begin
    if (rst) begin
        done_seen = 1'b0;
    end else begin
        check_bit("core_rst_o", !init_done, core_rst);
        if (init_done && !done_seen) begin
            if (stop_cnt != `PLL_INIT_LEN) begin
                fail_reason($sformatf("init_done_o rose after only %0d stops", stop_cnt));
            end
            done_seen = 1'b1;
        end else if (done_seen) begin
            check_bit("init_done_o", 1'b1, init_done);
        end
    end
end

task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
endtask

task automatic check_reset_values();
    check_bit("core_rst_o", 1'b1, core_rst);
    check_bit("init_done_o", 1'b0, init_done);
    check_bit("init_err_o", 1'b0, init_err);
    check_bit("scl_o", 1'b1, scl_oe);
    check_bit("sda_o", 1'b1, sda_oe);
    check_byte("sw_o", 8'h00, byte_t'(sw_out));
    check_state("seq_state", RUN, dut0.seq_inst.state_q);
endtask

// One clock of switch drive with fresh UART bits, UART outputs checked two cycles late
task automatic drive_cycle(input logic [`SW_W-1:0] sw_val);
    logic txd_bit;
    logic rts_bit;
    @(posedge clk);
    txd_bit = lfsr_bit();
    rts_bit = lfsr_bit();
    sw       <= sw_val;
    uart_txd <= txd_bit;
    uart_rts <= rts_bit;
    txd_hist = {txd_hist[1:0], txd_bit};
    rts_hist = {rts_hist[1:0], rts_bit};
    @(negedge clk);
    check_bit("uart_txd_o", txd_hist[2], txd_out);
    check_bit("uart_rts_o", rts_hist[2], rts_out);
endtask

task automatic check_writes(input int count);
    if (rx_q.size() != 3 * count) begin
        fail_reason($sformatf("Target got %0d bytes, expected %0d", rx_q.size(), 3 * count));
    end
    for (int i = 0; i < count; i++) begin
        check_byte($sformatf("dev_addr[%0d]", i), EXP_DEV, rx_q[3 * i]);
        check_byte($sformatf("reg_addr[%0d]", i), exp_reg[i], rx_q[3 * i + 1]);
        check_byte($sformatf("reg_data[%0d]", i), exp_dat[i], rx_q[3 * i + 2]);
    end
endtask

initial begin
    int glen;
    rst      = 1'b1;
    sw       = '0;
    uart_txd = 1'b0;
    uart_rts = 1'b0;
    lfsr_q   = 32'h53b0;

    // Normal init run
    apply_reset();
    check_reset_values();
    waiting_for = "init_done_o after the six PLL writes";
    do @(negedge clk); while (!init_done);
    check_bit("init_err_o", 1'b0, init_err);
    check_state("seq_state", DONE, dut0.seq_inst.state_q);
    if (stop_cnt != `PLL_INIT_LEN) begin
        fail_reason($sformatf("Saw %0d stop conditions instead of six", stop_cnt));
    end
    check_writes(`PLL_INIT_LEN);

    // Debounce table with one short glitch per row
    waiting_for = "the switch debounce table";
    for (int r = 0; r < SW_ROWS; r++) begin
        for (int c = 0; c < sw_hold_tab[r]; c++) begin
            drive_cycle(sw_val_tab[r]);
        end
        check_byte("sw_o", byte_t'(sw_exp_tab[r]), byte_t'(sw_out));
        glen = 1 + lfsr_bits(4) % (`DEBOUNCE_RATE - 1);
        for (int c = 0; c < glen; c++) begin
            drive_cycle(~sw_val_tab[r]);
            check_byte("sw_o", byte_t'(sw_exp_tab[r]), byte_t'(sw_out));
        end
        for (int c = 0; c < SETTLE_CYC; c++) begin
            drive_cycle(sw_val_tab[r]);
            check_byte("sw_o", byte_t'(sw_exp_tab[r]), byte_t'(sw_out));
        end
    end
    if (stop_cnt != `PLL_INIT_LEN) begin
        fail_reason("Extra I2C traffic after init_done_o");
    end

    // NACK run, target leaves every ACK high
    nack_mode = 1'b1;
    apply_reset();
    check_reset_values();
    waiting_for = "init_err_o after the first NACK";
    do @(negedge clk); while (!init_err);
    waiting_for = "the end of the NACK watch window";
    repeat (NACK_WATCH_CYC) begin
        @(negedge clk);
        check_bit("init_err_o", 1'b1, init_err);
        check_bit("core_rst_o", 1'b1, core_rst);
        check_bit("init_done_o", 1'b0, init_done);
    end
    check_state("seq_state", ERR, dut0.seq_inst.state_q);
    if (stop_cnt != 1) begin
        fail_reason($sformatf("Saw %0d transactions after NACK instead of one", stop_cnt));
    end
    check_writes(1);

    $display("TEST RESULT: PASS");
    $finish;
end

endmodule

// File: files.f
+incdir+rtl
rtl/board_pkg.sv
rtl/pll_init_rom.sv
rtl/pll_init_seq.sv
rtl/i2c_master.sv
rtl/input_cond.sv
rtl/board_top.sv
sim/board_assert.sv
sim/board_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the board management testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module board_tb -Mdir "$OBJ" -o board_sim -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/board_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

exit 0
